// ==== common/icache_array_if.sv ====
interface icache_array_if;

    // From the controller
    icache_pkg::index_t      rd_index;     // Set to read
    icache_pkg::tag_t        req_tag;      // Tag under lookup, also the fill tag
    logic                    fill_we;
    icache_pkg::way_mask_t   fill_way;     // One-hot
    icache_pkg::index_t      fill_index;
    icache_pkg::line_t       fill_line;

    // From the stores, one cycle after rd_index
    icache_pkg::way_mask_t   hit_way;
    icache_pkg::way_mask_t   valid_way;
    icache_pkg::line_array_t line_way;
    logic                    init_busy;    // Tag walk in progress

    modport ctrl (
        output rd_index, req_tag, fill_we, fill_way, fill_index, fill_line,
        input  hit_way, valid_way, line_way, init_busy
    );

    modport tags (
        input  rd_index, req_tag, fill_we, fill_way, fill_index,
        output hit_way, valid_way, init_busy
    );

    modport data (
        input  rd_index, fill_we, fill_way, fill_index, fill_line,
        output line_way
    );

endinterface

// ==== common/icache_pkg.sv ====
package icache_pkg;

    // ====================
    // Cache geometry
    // ====================
    localparam int ADDR_W         = 32;                        // Byte address
    localparam int WORD_W         = 32;
    localparam int WAYS           = 4;
    localparam int SETS           = 16;                        // Kept small for a short init walk
    localparam int INDEX_W        = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int WSEL_W         = 2;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;   // 128
    localparam int TAG_W          = 24;

    // Address field positions
    localparam int WSEL_LSB  = 2;                              // Bits 3:2
    localparam int INDEX_LSB = WSEL_LSB + WSEL_W;              // Bits 7:4
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;            // Bits 31:8

    // ====================
    // Replacement LFSR
    // ====================
    localparam int             LFSR_W    = 4;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 4'hf;            // Never all zero
    localparam int             WAY_SEL_W = 2;                  // LFSR bits used as way number

    // ====================
    // Types
    // ====================
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WAYS-1:0]    way_mask_t;                    // One bit per way

    // One tag-way entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // Per-way line read results
    typedef line_t [WAYS-1:0] line_array_t;

endpackage

// ==== controller/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // Core request
    input  logic                i_req_valid,
    output logic                o_req_ready,
    input  icache_pkg::addr_t   i_req_addr,
    // Core response
    output logic                o_rsp_valid,
    output icache_pkg::word_t   o_rsp_data,
    input  logic                i_rsp_ready,
    // Memory request
    output logic                o_mem_req_valid,
    output icache_pkg::addr_t   o_mem_addr,
    input  logic                i_mem_req_ready,
    // Memory response
    input  logic                i_mem_rsp_valid,
    input  icache_pkg::line_t   i_mem_rsp_data,
    output logic                o_mem_rsp_ready,
    icache_array_if.ctrl        arr
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_REQ,
        MEM_WAIT,
        RESPOND
    } state_t;

    state_t                         state;
    icache_pkg::addr_t              addr_q;      // Request under service
    icache_pkg::addr_t              look_addr;
    logic [icache_pkg::WSEL_W-1:0]  wsel;
    logic [icache_pkg::LFSR_W-1:0]  lfsr;
    icache_pkg::way_mask_t          victim;
    icache_pkg::way_mask_t          victim_q;
    icache_pkg::way_mask_t          invalid;
    icache_pkg::line_t              hit_line;
    icache_pkg::word_t              rsp_data_q;
    logic                           hit;
    logic                           accept;
    logic                           fill_done;

    function automatic icache_pkg::word_t pick_word(
        input icache_pkg::line_t             line,
        input logic [icache_pkg::WSEL_W-1:0] sel
    );
        return line[sel * icache_pkg::WORD_W +: icache_pkg::WORD_W];   // Word 0 in low bits
    endfunction

    // ====================
    // Array lookup
    // ====================
    assign accept    = i_req_valid && o_req_ready;
    assign look_addr = (state == IDLE) ? i_req_addr : addr_q;   // Read ahead on the request
    assign wsel      = addr_q[icache_pkg::WSEL_LSB +: icache_pkg::WSEL_W];
    assign hit       = |arr.hit_way;                            // Meaningful in LOOKUP only

    assign arr.rd_index = look_addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
    assign arr.req_tag  = look_addr[icache_pkg::TAG_LSB +: icache_pkg::TAG_W];

    // AND-OR line mux over the hit way
    always_comb
    begin
        hit_line = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++)
        begin
            if (arr.hit_way[w])
            begin
                hit_line = hit_line | arr.line_way[w];
            end
        end
    end

    // Victim: lowest invalid way, else LFSR pick
    always_comb
    begin
        invalid = ~arr.valid_way;
        if (invalid != '0)
        begin
            victim = invalid & (~invalid + icache_pkg::way_mask_t'(1));  // Lowest set bit
        end
        else
        begin
            victim = icache_pkg::way_mask_t'(1) << lfsr[icache_pkg::WAY_SEL_W-1:0];
        end
    end

    // ====================
    // Request FSM
    // ====================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state <= IDLE;
            lfsr  <= icache_pkg::LFSR_SEED;
        end
        else
        begin
            case (state)
                IDLE:     if (accept) state <= LOOKUP;
                LOOKUP:
                begin
                    if (hit)
                    begin
                        state <= RESPOND;
                    end
                    else
                    begin
                        state <= MEM_REQ;
                        lfsr  <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};   // Step once per miss
                    end
                end
                MEM_REQ:  if (i_mem_req_ready) state <= MEM_WAIT;
                MEM_WAIT: if (i_mem_rsp_valid) state <= RESPOND;   // Fill written here
                RESPOND:  if (i_rsp_ready) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            addr_q <= i_req_addr;
        end
        if (state == LOOKUP)
        begin
            victim_q <= victim;                     // Held through the fill
        end
        if (state == LOOKUP && hit)
        begin
            rsp_data_q <= pick_word(hit_line, wsel);
        end
        else if (fill_done)
        begin
            rsp_data_q <= pick_word(i_mem_rsp_data, wsel);   // Answer from fetched line
        end
    end

    assign fill_done = (state == MEM_WAIT) && i_mem_rsp_valid;

    // Fill port
    assign arr.fill_we    = fill_done;
    assign arr.fill_way   = victim_q;
    assign arr.fill_index = addr_q[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
    assign arr.fill_line  = i_mem_rsp_data;

    // Outputs
    assign o_req_ready     = (state == IDLE) && !arr.init_busy;
    assign o_rsp_valid     = (state == RESPOND);
    assign o_rsp_data      = rsp_data_q;
    assign o_mem_req_valid = (state == MEM_REQ);
    assign o_mem_addr      = {addr_q[icache_pkg::ADDR_W-1:icache_pkg::INDEX_LSB],
                              {icache_pkg::INDEX_LSB{1'b0}}};         // Line aligned
    assign o_mem_rsp_ready = (state == MEM_WAIT);

    // Handshake holds
    a_mem_req_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mem_req_valid && !i_mem_req_ready |=> o_mem_req_valid && $stable(o_mem_addr))
    else $error("Memory request dropped or changed before ready");

    a_rsp_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_data))
    else $error("Core response dropped or changed before ready");

endmodule

// ==== data_store/icache_data_store.sv ====
module icache_data_store (
    input  logic         i_clk,
    icache_array_if.data arr
);

    // One line RAM per way, all read on the same set
    for (genvar w = 0; w < icache_pkg::WAYS; w++)
    begin : g_way
        way_ram #(
            .T_ENTRY (icache_pkg::line_t)
        ) u_line_ram (
            .i_clk   (i_clk),
            .i_we    (arr.fill_we & arr.fill_way[w]),   // Victim way only
            .i_waddr (arr.fill_index),
            .i_wdata (arr.fill_line),
            .i_raddr (arr.rd_index),
            .o_rdata (arr.line_way[w])
        );
    end

endmodule

// ==== design/icache_top.sv ====
module icache_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_flush,
    // Core side
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  icache_pkg::addr_t i_req_addr,
    output logic              o_rsp_valid,
    output icache_pkg::word_t o_rsp_data,
    input  logic              i_rsp_ready,
    // Memory side
    output logic              o_mem_req_valid,
    output icache_pkg::addr_t o_mem_addr,
    input  logic              i_mem_req_ready,
    input  logic              i_mem_rsp_valid,
    input  icache_pkg::line_t i_mem_rsp_data,
    output logic              o_mem_rsp_ready
);

    icache_array_if u_arr ();     // Controller to both stores

    icache_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_addr      (i_req_addr),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp_data      (o_rsp_data),
        .i_rsp_ready     (i_rsp_ready),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_addr      (o_mem_addr),
        .i_mem_req_ready (i_mem_req_ready),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_data  (i_mem_rsp_data),
        .o_mem_rsp_ready (o_mem_rsp_ready),
        .arr             (u_arr.ctrl)
    );

    // Tags and lines read side by side on the same set
    icache_tag_store u_tag_store (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .arr     (u_arr.tags)
    );

    icache_data_store u_data_store (
        .i_clk (i_clk),
        .arr   (u_arr.data)
    );

endmodule

// ==== design/way_ram.sv ====
module way_ram #(
    parameter type T_ENTRY = logic
) (
    input  logic               i_clk,
    input  logic               i_we,
    input  icache_pkg::index_t i_waddr,
    input  T_ENTRY             i_wdata,
    input  icache_pkg::index_t i_raddr,
    output T_ENTRY             o_rdata
);

    T_ENTRY mem [icache_pkg::SETS];    // One entry per set

    // Write port and registered read port
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];       // Old data on same-address collision
    end

endmodule

// ==== filelist.f ====
common/icache_pkg.sv
common/icache_array_if.sv
design/way_ram.sv
tag_store/icache_tag_store.sv
data_store/icache_data_store.sv
controller/icache_ctrl.sv
design/icache_top.sv
tests/tb_clkgen.sv
tests/icache_checker.sv
tests/icache_tb.sv

// ==== tag_store/icache_tag_store.sv ====
module icache_tag_store (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_flush,
    icache_array_if.tags arr
);

    icache_pkg::index_t     init_cnt;                     // Walk position
    logic                   init_busy;
    logic                   walk_q;                       // Walk active last cycle
    icache_pkg::tag_t       tag_q;                        // Tag aligned with read data
    icache_pkg::index_t     wr_index;
    icache_pkg::tag_entry_t wr_entry;
    icache_pkg::tag_entry_t rd_entry [icache_pkg::WAYS];

    // ====================
    // Init walk
    // ====================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)                          // Both restart the walk
        begin
            init_busy <= 1'b1;
            init_cnt  <= '0;
        end
        else if (init_busy)
        begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == icache_pkg::index_t'(icache_pkg::SETS - 1))
            begin
                init_busy <= 1'b0;                        // Last set cleared
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            walk_q <= 1'b1;
        end
        else
        begin
            walk_q <= init_busy;
        end
    end

    always_ff @(posedge i_clk)
    begin
        tag_q <= arr.req_tag;                             // Compare one cycle later
    end

    // Walk overrides the fill port
    assign wr_index = init_busy ? init_cnt : arr.fill_index;

    always_comb
    begin
        wr_entry = '0;                                    // Invalid entry during walk
        if (!init_busy)
        begin
            wr_entry.valid = 1'b1;
            wr_entry.tag   = arr.req_tag;
        end
    end

    // ====================
    // Ways and compare
    // ====================
    for (genvar w = 0; w < icache_pkg::WAYS; w++)
    begin : g_way
        way_ram #(
            .T_ENTRY (icache_pkg::tag_entry_t)
        ) u_tag_ram (
            .i_clk   (i_clk),
            .i_we    (init_busy | (arr.fill_we & arr.fill_way[w])),  // All ways while walking
            .i_waddr (wr_index),
            .i_wdata (wr_entry),
            .i_raddr (arr.rd_index),
            .o_rdata (rd_entry[w])
        );

        assign arr.valid_way[w] = rd_entry[w].valid;
        assign arr.hit_way[w]   = rd_entry[w].valid && (rd_entry[w].tag == tag_q);
    end

    assign arr.init_busy = init_busy;

    // Controller never fills a tag that already sits in the set
    a_hit_onehot : assert property (@(posedge i_clk)
        disable iff (!i_rst_n || init_busy || walk_q)
        $onehot0(arr.hit_way))
    else $error("Tag store: more than one way hit");

endmodule

// ==== tests/icache_checker.sv ====
module icache_checker (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_flush,
    input  logic              i_req_valid,
    input  logic              i_req_ready,
    input  icache_pkg::addr_t i_req_addr,
    input  logic              i_rsp_valid,
    input  icache_pkg::word_t i_rsp_data,
    input  logic              i_rsp_ready,
    input  logic              i_mem_req_valid,
    input  icache_pkg::addr_t i_mem_addr,
    input  logic              i_mem_req_ready,
    input  logic              i_mem_rsp_ready,
    output int                o_mismatch_cnt,
    output int                o_protocol_cnt,
    output int                o_rsp_cnt
);

    localparam int HIT_LATENCY = 1;                  // Accept edge to response edge

    int unsigned       fill_cnt [bit [31:0]];        // Fills per line since reset or flush
    int unsigned       set_lines [icache_pkg::SETS]; // Distinct lines filled per set
    int                walk_left = 0;                // Edges left in the init walk
    int                cycle = 0;
    int                acc_cycle;
    int                rsp_cycle;
    int                mem_reqs;                     // Memory requests of this transaction
    bit                pending = 1'b0;
    bit                rsp_seen = 1'b0;
    bit                rsp_hold = 1'b0;
    bit                mem_hold = 1'b0;
    bit                rst_seen = 1'b0;
    bit                expect_miss;
    bit                expect_hit;
    icache_pkg::addr_t cur_addr;
    icache_pkg::addr_t held_mem_addr;
    icache_pkg::word_t held_rsp_data;

    initial
    begin
        o_mismatch_cnt = 0;
        o_protocol_cnt = 0;
        o_rsp_cnt      = 0;
    end

    // ====================
    // Reference model
    // ====================
    // Expected memory word, a fixed mix of the word address bits
    function automatic icache_pkg::word_t ref_word(input icache_pkg::addr_t addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h0f1e_2d3c;
    endfunction

    function automatic bit [31:0] line_of(input icache_pkg::addr_t addr);
        return {addr[31:4], 4'h0};                   // 16-byte lines
    endfunction

    function automatic int set_of(input icache_pkg::addr_t addr);
        return int'(addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W]);
    endfunction

    task automatic protocol_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        o_protocol_cnt++;
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        o_mismatch_cnt++;
    endtask

    // Nothing cached after reset or flush
    task automatic clear_model();
        fill_cnt.delete();
        foreach (set_lines[s])
            set_lines[s] = 0;
        walk_left = icache_pkg::SETS;
    endtask

    task automatic check_mem_request();
        bit [31:0] line;
        line = line_of(cur_addr);
        if (!pending)
            protocol_error("memory request with no core request open");
        else if (i_mem_addr != line)
            report_mismatch($sformatf("memory address %h, expected %h", i_mem_addr, line));
        mem_reqs++;
        if (fill_cnt.exists(line))
            fill_cnt[line]++;                        // Refill after an eviction
        else
        begin
            fill_cnt[line] = 1;
            set_lines[set_of(cur_addr)]++;
        end
    endtask

    task automatic check_response();
        icache_pkg::word_t exp;
        exp = ref_word(cur_addr);
        if (i_rsp_data != exp)
            report_mismatch($sformatf("addr %h read %h, expected %h",
                                      cur_addr, i_rsp_data, exp));
        if (expect_miss && mem_reqs != 1)
            protocol_error($sformatf("first access to line %h made %0d memory requests",
                                     line_of(cur_addr), mem_reqs));
        if (expect_hit && mem_reqs != 0)
            protocol_error($sformatf("cached line %h was fetched again", line_of(cur_addr)));
        // Output is sampled one edge after it rises
        if (mem_reqs == 0 && rsp_cycle - acc_cycle != HIT_LATENCY + 1)
            protocol_error($sformatf("hit on %h answered %0d cycles after acceptance",
                                     cur_addr, rsp_cycle - acc_cycle - 1));
        pending  = 1'b0;
        rsp_seen = 1'b0;
        o_rsp_cnt++;
    endtask

    // ====================
    // Monitor
    // ====================
    always @(posedge i_clk)
    begin
        cycle++;
        if (!i_rst_n)
        begin
            clear_model();
            pending  = 1'b0;
            rsp_seen = 1'b0;
            rsp_hold = 1'b0;
            mem_hold = 1'b0;
            rst_seen = 1'b1;
        end
        else
        begin
            if (rst_seen)
            begin
                if (i_req_ready || i_rsp_valid || i_mem_req_valid || i_mem_rsp_ready)
                    protocol_error("a handshake output was high right after reset");
                rst_seen = 1'b0;
            end
            if (walk_left > 0)
            begin
                if (i_req_ready)
                    protocol_error("request ready raised during the init walk");
                walk_left--;
            end

            // Held handshakes from the last edge
            if (rsp_hold && (!i_rsp_valid || i_rsp_data !== held_rsp_data))
                protocol_error("core response dropped or changed before ready");
            if (mem_hold && (!i_mem_req_valid || i_mem_addr !== held_mem_addr))
                protocol_error("memory request dropped or changed before ready");
            rsp_hold      = i_rsp_valid && !i_rsp_ready;
            held_rsp_data = i_rsp_data;
            mem_hold      = i_mem_req_valid && !i_mem_req_ready;
            held_mem_addr = i_mem_addr;

            // Busy cache must not offer to take a request
            if (i_req_ready && pending)
                protocol_error("request ready high while another request is open");

            if (i_req_valid && i_req_ready)
            begin
                pending     = 1'b1;
                cur_addr    = i_req_addr;
                acc_cycle   = cycle;
                mem_reqs    = 0;
                expect_miss = !fill_cnt.exists(line_of(i_req_addr));
                expect_hit  = !expect_miss && set_lines[set_of(i_req_addr)] <= icache_pkg::WAYS;
            end
            if (i_rsp_valid && !rsp_seen)
            begin
                if (!pending)
                    protocol_error("response with no request open");
                rsp_seen  = 1'b1;
                rsp_cycle = cycle;
            end
            if (i_mem_req_valid && i_mem_req_ready)
                check_mem_request();
            if (i_rsp_valid && i_rsp_ready && pending)
                check_response();
            if (i_flush)
                clear_model();                       // Walk restarts here
        end
    end

endmodule

// ==== tests/icache_tb.sv ====
module icache_tb;

    // About 200 requests under 15 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              req_valid;
    logic              req_ready;
    icache_pkg::addr_t req_addr;
    logic              rsp_valid;
    icache_pkg::word_t rsp_data;
    logic              rsp_ready;
    logic              mem_req_valid;
    icache_pkg::addr_t mem_addr;
    logic              mem_req_ready;
    logic              mem_rsp_valid;
    icache_pkg::line_t mem_rsp_data;
    logic              mem_rsp_ready;
    int                mismatch_cnt;
    int                protocol_cnt;
    int                rsp_cnt;
    int                other_cnt = 0;
    int                cycle_cnt = 0;
    integer            seed = 27970;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    icache_top i_icache_top (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_flush         (flush),
        .i_req_valid     (req_valid),
        .o_req_ready     (req_ready),
        .i_req_addr      (req_addr),
        .o_rsp_valid     (rsp_valid),
        .o_rsp_data      (rsp_data),
        .i_rsp_ready     (rsp_ready),
        .o_mem_req_valid (mem_req_valid),
        .o_mem_addr      (mem_addr),
        .i_mem_req_ready (mem_req_ready),
        .i_mem_rsp_valid (mem_rsp_valid),
        .i_mem_rsp_data  (mem_rsp_data),
        .o_mem_rsp_ready (mem_rsp_ready)
    );

    icache_checker u_checker (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_flush         (flush),
        .i_req_valid     (req_valid),
        .i_req_ready     (req_ready),
        .i_req_addr      (req_addr),
        .i_rsp_valid     (rsp_valid),
        .i_rsp_data      (rsp_data),
        .i_rsp_ready     (rsp_ready),
        .i_mem_req_valid (mem_req_valid),
        .i_mem_addr      (mem_addr),
        .i_mem_req_ready (mem_req_ready),
        .i_mem_rsp_ready (mem_rsp_ready),
        .o_mismatch_cnt  (mismatch_cnt),
        .o_protocol_cnt  (protocol_cnt),
        .o_rsp_cnt       (rsp_cnt)
    );

    // ====================
    // Helpers
    // ====================
    function automatic icache_pkg::addr_t make_addr(input icache_pkg::tag_t tag,
                                                    input int set, input int word);
        return {tag, set[3:0], word[1:0], 2'b00};
    endfunction

    function automatic icache_pkg::tag_t base_tag(input int t);
        return icache_pkg::tag_t'(32'h0000_0100 + t * 32'h31);
    endfunction

    // Memory line, word 0 in the low bits
    function automatic icache_pkg::line_t build_line(input icache_pkg::addr_t base);
        icache_pkg::line_t line;
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++)
            line[w * 32 +: 32] = u_checker.ref_word(base + w * 4);
        return line;
    endfunction

    // Called and returns on a falling edge
    task automatic send_request(input icache_pkg::addr_t addr, input bit backpressure);
        bit done;
        done      = 1'b0;
        req_valid = 1'b1;
        req_addr  = addr;
        while (!req_ready)
            @(negedge clk);
        @(negedge clk);                              // Taken at the edge just passed
        req_valid = 1'b0;
        while (!done)
        begin
            rsp_ready = backpressure ? ($unsigned($random(seed)) % 3 != 0) : 1'b1;
            done      = rsp_valid && rsp_ready;
            @(negedge clk);
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // ====================
    // Memory responder
    // ====================
    initial
    begin
        int                delay;
        icache_pkg::addr_t line_addr;
        forever
        begin
            @(negedge clk);
            if (mem_req_valid)
            begin
                delay = $unsigned($random(seed)) % 6;   // 0 to 5 cycles
                repeat (delay) @(negedge clk);
                mem_req_ready = 1'b1;
                line_addr     = mem_addr;
                @(negedge clk);
                mem_req_ready = 1'b0;
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                mem_rsp_data  = build_line(line_addr);
                mem_rsp_valid = 1'b1;
                while (!mem_rsp_ready)
                    @(negedge clk);
                @(negedge clk);
                mem_rsp_valid = 1'b0;
            end
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ====================
    // Stimulus
    // ====================
    initial
    begin
        int               n_sent;
        icache_pkg::tag_t tag;
        int               set;
        flush         = 1'b0;
        req_valid     = 1'b0;
        req_addr      = '0;
        rsp_ready     = 1'b1;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        n_sent        = 0;
        wait (rst_n);
        @(negedge clk);

        // Cold misses, four tags in every set
        for (int t = 0; t < icache_pkg::WAYS; t++)
            for (int s = 0; s < icache_pkg::SETS; s++)
            begin
                send_request(make_addr(base_tag(t), s, t), 1'b0);
                n_sent++;
            end

        // Same lines again, other words, all hits
        for (int t = 0; t < icache_pkg::WAYS; t++)
            for (int s = 0; s < icache_pkg::SETS; s++)
            begin
                send_request(make_addr(base_tag(t), s, t + 1), 1'b0);
                n_sent++;
            end

        // Flush, then once-cached lines miss again
        pulse_flush();
        for (int s = 0; s < icache_pkg::SETS; s++)
        begin
            send_request(make_addr(base_tag(s % 4), s, s), 1'b0);
            n_sent++;
        end

        // Eight tags over two sets, LFSR eviction, random back-pressure
        for (int i = 0; i < 60; i++)
        begin
            tag = icache_pkg::tag_t'(32'h0000_a000 + $unsigned($random(seed)) % 8);
            set = ($random(seed) & 1) ? 3 : 9;
            send_request(make_addr(tag, set, $unsigned($random(seed)) % 4), 1'b1);
            n_sent++;
        end

        repeat (2) @(negedge clk);
        if (rsp_cnt != n_sent)
        begin
            $display("ERROR: %0d requests sent but %0d responses seen", n_sent, rsp_cnt);
            other_cnt++;
        end
        $display("Errors: %0d mismatches, %0d protocol errors, %0d other",
                 mismatch_cnt, protocol_cnt, other_cnt);
        if (mismatch_cnt == 0 && protocol_cnt == 0 && other_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== tests/tb_clkgen.sv ====
module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD = 20;    // Period 40
    localparam int RST_CYCLES  = 2;

    initial
    begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset held over two rising edges, released on a falling edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule
